/* design/alu_pkg.sv */
// Widths, encodings and packed structs shared by the ALU lane RTL and its testbench.
package alu_pkg;

  localparam int DATA_W    = 64;
  localparam int NUM_FWD   = 4;               // Result-forwarding buses.
  localparam int FWD_IDX_W = $clog2(NUM_FWD);
  localparam int SHAMT_W   = $clog2(DATA_W);  // Shift count, 64-bit form.
  localparam int SHAMT32_W = SHAMT_W - 1;     // Shift count, 32-bit form.

  typedef logic [DATA_W-1:0]    word_t;
  typedef word_t [NUM_FWD-1:0]  fwd_bus_t;
  typedef logic [FWD_IDX_W-1:0] fwd_idx_t;
  typedef logic [SHAMT_W-1:0]   shamt_t;

  // Where an operand comes from.
  typedef enum logic [1:0] {
    src_issue    = 2'd0,
    src_bus_now  = 2'd1,
    src_bus_prev = 2'd2
  } fwd_mode_e;

  typedef struct packed {
    fwd_mode_e mode;
    fwd_idx_t  idx;
  } fwd_sel_t;

  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_and = 4'd2,
    op_or  = 4'd3,
    op_xor = 4'd4,
    op_shl = 4'd5,
    op_shr = 4'd6,
    op_sar = 4'd7,
    op_cmp = 4'd8
  } alu_op_e;

  typedef struct packed {
    alu_op_e op;
    logic    is32;
  } alu_uop_t;

  typedef struct packed {
    logic     valid;
    alu_uop_t uop;
    word_t    a;
    word_t    b;
    fwd_sel_t a_sel;
    fwd_sel_t b_sel;
  } alu_issue_t;

  typedef enum logic [1:0] {
    unit_add   = 2'd0,
    unit_logic = 2'd1,
    unit_shift = 2'd2
  } alu_unit_e;

  typedef enum logic [1:0] {
    logic_and = 2'd0,
    logic_or  = 2'd1,
    logic_xor = 2'd2
  } logic_fn_e;

  typedef struct packed {
    logic      valid;
    logic      is32;
    alu_unit_e unit;
    logic      invert_b;     // Subtract.
    logic_fn_e logic_fn;
    logic      shift_arith;
    logic      shift_right;
    logic      wr_result;
  } alu_ctrl_t;

  typedef struct packed {
    logic zero;
    logic sign;
    logic carry;
    logic overflow;
  } alu_flags_t;

  typedef struct packed {
    alu_flags_t flags;
    logic       wr_result;
  } alu_ret_t;

endpackage

/* design/operand_forward.sv */
// Stage-1 operand select between the issued value and the forwarding buses, now or one cycle back.
`timescale 1ns/1ps

module operand_forward
  import alu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  word_t    value,
  input  fwd_sel_t sel,
  input  fwd_bus_t fwd_bus,
  output word_t    operand
);

  fwd_bus_t fwd_prev;  // Bus values from the previous cycle.
  word_t    picked;

  // One cycle of history on every bus.
  always_ff @(posedge clk) begin
    fwd_prev <= fwd_bus;
  end

  always_comb begin
    case (sel.mode)
      src_bus_now: begin
        picked = fwd_bus[sel.idx];
      end
      src_bus_prev: begin
        picked = fwd_prev[sel.idx];
      end
      default: begin
        picked = value;  // Issued value.
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      operand <= '0;
    end else begin
      operand <= picked;
    end
  end

endmodule

/* design/op_decode.sv */
// Stage-1 decoder; turns an issued op into registered control fields for the execute stage.
`timescale 1ns/1ps

module op_decode
  import alu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      flush,
  input  logic      valid,
  input  alu_uop_t  uop,
  output alu_ctrl_t ctrl
);

  alu_ctrl_t dec;

  always_comb begin
    dec             = '0;
    dec.valid       = valid;
    dec.is32        = uop.is32;
    dec.wr_result   = 1'b1;
    case (uop.op)
      op_add: dec.unit = unit_add;
      op_sub: begin
        dec.unit     = unit_add;
        dec.invert_b = 1'b1;
      end
      op_cmp: begin
        dec.unit      = unit_add;
        dec.invert_b  = 1'b1;
        dec.wr_result = 1'b0;  // Flags only.
      end
      op_and: begin
        dec.unit     = unit_logic;
        dec.logic_fn = logic_and;
      end
      op_or: begin
        dec.unit     = unit_logic;
        dec.logic_fn = logic_or;
      end
      op_xor: begin
        dec.unit     = unit_logic;
        dec.logic_fn = logic_xor;
      end
      op_shl: dec.unit = unit_shift;
      op_shr: begin
        dec.unit        = unit_shift;
        dec.shift_right = 1'b1;
      end
      op_sar: begin
        dec.unit        = unit_shift;
        dec.shift_right = 1'b1;
        dec.shift_arith = 1'b1;
      end
      default: dec.valid = 1'b0;  // Unknown op is dropped.
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl <= '0;
    end else begin
      ctrl       <= dec;
      ctrl.valid <= dec.valid & ~flush;
    end
  end

endmodule

/* design/alu_shift.sv */
// Combinational logical and arithmetic shifter for the execute stage, 64-bit and 32-bit forms.
`timescale 1ns/1ps

module alu_shift
  import alu_pkg::*;
(
  input  word_t value,
  input  word_t amount,
  input  logic  is32,
  input  logic  arith,
  input  logic  right,
  output word_t shifted
);

  word_t  src;
  word_t  res;
  shamt_t amt;

  // In 32-bit form the low half is widened so one 64-bit shifter serves both.
  always_comb begin
    if (is32) begin
      src = {{(DATA_W/2){arith & value[DATA_W/2-1]}}, value[DATA_W/2-1:0]};
      amt = {1'b0, amount[SHAMT32_W-1:0]};
    end else begin
      src = value;
      amt = amount[SHAMT_W-1:0];
    end
  end

  always_comb begin
    if (!right) begin
      res = src << amt;
    end else if (arith) begin
      res = word_t'($signed(src) >>> amt);
    end else begin
      res = src >> amt;
    end
  end

  // Upper half is zero for 32-bit ops.
  always_comb begin
    if (is32) begin
      shifted = {{(DATA_W/2){1'b0}}, res[DATA_W/2-1:0]};
    end else begin
      shifted = res;
    end
  end

endmodule

/* design/alu_exec.sv */
// Stage-2 execute; adder, logic unit and shifter with flag generation and the result register.
`timescale 1ns/1ps

module alu_exec
  import alu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      flush,
  input  word_t     opa,
  input  word_t     opb,
  input  alu_ctrl_t ctrl,
  output word_t     result,
  output alu_ret_t  ret,
  output logic      result_valid
);

  localparam int HALF = DATA_W / 2;

  word_t             b_in;
  logic [DATA_W:0]   sum;
  word_t             logic_res;
  word_t             shift_res;
  word_t             raw;
  word_t             sized;
  logic              carry32;
  logic              a_msb;
  logic              b_msb;
  alu_flags_t        flags;

  assign b_in = ctrl.invert_b ? ~opb : opb;
  assign sum  = {1'b0, opa} + {1'b0, b_in} + {{DATA_W{1'b0}}, ctrl.invert_b};

  // Carry out of bit 31 recovered from the sum bit above it.
  assign carry32 = sum[HALF] ^ opa[HALF] ^ b_in[HALF];

  always_comb begin
    case (ctrl.logic_fn)
      logic_or:  logic_res = opa | opb;
      logic_xor: logic_res = opa ^ opb;
      default:   logic_res = opa & opb;
    endcase
  end

  alu_shift shift_i (
    .value   (opa),
    .amount  (opb),
    .is32    (ctrl.is32),
    .arith   (ctrl.shift_arith),
    .right   (ctrl.shift_right),
    .shifted (shift_res)
  );

  always_comb begin
    case (ctrl.unit)
      unit_logic: raw = logic_res;
      unit_shift: raw = shift_res;
      default:    raw = sum[DATA_W-1:0];
    endcase
    sized = ctrl.is32 ? {{HALF{1'b0}}, raw[HALF-1:0]} : raw;
  end

  assign a_msb = ctrl.is32 ? opa[HALF-1] : opa[DATA_W-1];
  assign b_msb = ctrl.is32 ? b_in[HALF-1] : b_in[DATA_W-1];

  always_comb begin
    flags.zero     = (sized == '0);
    flags.sign     = ctrl.is32 ? sized[HALF-1] : sized[DATA_W-1];
    flags.carry    = 1'b0;
    flags.overflow = 1'b0;
    if (ctrl.unit == unit_add) begin
      flags.carry    = ctrl.is32 ? carry32 : sum[DATA_W];
      flags.overflow = (a_msb == b_msb) && (flags.sign != a_msb);  // Signed overflow.
    end
  end

  always_ff @(posedge clk) begin
    result        <= sized;
    ret.flags     <= flags;
    ret.wr_result <= ctrl.wr_result;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= ctrl.valid & ~flush;
    end
  end

endmodule

/* design/alu_lane.sv */
// Integer ALU lane top; operand forwarding and decode in stage 1, execute in stage 2.
`timescale 1ns/1ps

module alu_lane
  import alu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       flush,
  input  alu_issue_t issue,
  input  fwd_bus_t   fwd_bus,
  output word_t      result,
  output alu_ret_t   ret,
  output logic       result_valid
);

  word_t     opa;
  word_t     opb;
  alu_ctrl_t ctrl;

  operand_forward fwd_a_i (
    .clk     (clk),
    .rst     (rst),
    .value   (issue.a),
    .sel     (issue.a_sel),
    .fwd_bus (fwd_bus),
    .operand (opa)
  );

  operand_forward fwd_b_i (
    .clk     (clk),
    .rst     (rst),
    .value   (issue.b),
    .sel     (issue.b_sel),
    .fwd_bus (fwd_bus),
    .operand (opb)
  );

  op_decode decode_i (
    .clk   (clk),
    .rst   (rst),
    .flush (flush),
    .valid (issue.valid),
    .uop   (issue.uop),
    .ctrl  (ctrl)
  );

  alu_exec exec_i (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .opa          (opa),
    .opb          (opb),
    .ctrl         (ctrl),
    .result       (result),
    .ret          (ret),
    .result_valid (result_valid)
  );

endmodule

/* sim/alu_model.svh */
// Reference model of the ALU lane, included by the testbench to predict operands, results and flags.
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

function automatic word_t expect_operand(input word_t value, input fwd_sel_t sel,
                                         input fwd_bus_t bus_now, input fwd_bus_t bus_prev);
  case (sel.mode)
    src_bus_now:  return bus_now[sel.idx];
    src_bus_prev: return bus_prev[sel.idx];   // Bus as it was one cycle before issue.
    default:      return value;
  endcase
endfunction

function automatic word_t expect_result(input alu_op_e op, input logic is32,
                                        input word_t a, input word_t b);
  word_t       r;
  logic [31:0] lo;
  int          n;
  lo = a[31:0];
  n  = is32 ? int'(b[4:0]) : int'(b[5:0]);
  case (op)
    op_add:         r = a + b;
    op_sub, op_cmp: r = a - b;
    op_and:         r = a & b;
    op_or:          r = a | b;
    op_xor:         r = a ^ b;
    op_shl:         r = a << n;
    op_shr:         r = a >> n;
    default:        r = $signed(a) >>> n;
  endcase
  // Narrow form works on the low word only.
  if (is32) begin
    case (op)
      op_shl:  r = {32'd0, lo << n};
      op_shr:  r = {32'd0, lo >> n};
      op_sar:  r = {32'd0, $signed(lo) >>> n};
      default: r = {32'd0, r[31:0]};
    endcase
  end
  return r;
endfunction

function automatic alu_ret_t expect_ret(input alu_op_e op, input logic is32,
                                        input word_t a, input word_t b);
  alu_ret_t           t;
  word_t              r;
  logic signed [65:0] sa;
  logic signed [65:0] sb;
  logic signed [65:0] exact;
  logic signed [65:0] kept;
  logic [64:0]        usum;
  r            = expect_result(op, is32, a, b);
  t            = '0;
  t.wr_result  = (op != op_cmp);
  t.flags.zero = (r == '0);
  t.flags.sign = is32 ? r[31] : r[63];
  if (op == op_add || op == op_sub || op == op_cmp) begin
    sa   = is32 ? {{34{a[31]}}, a[31:0]} : {{2{a[63]}}, a};
    sb   = is32 ? {{34{b[31]}}, b[31:0]} : {{2{b[63]}}, b};
    kept = is32 ? {{34{r[31]}}, r[31:0]} : {{2{r[63]}}, r};
    usum = is32 ? {33'd0, a[31:0]} + {33'd0, b[31:0]} : {1'b0, a} + {1'b0, b};
    if (op == op_add) begin
      exact         = sa + sb;
      t.flags.carry = is32 ? usum[32] : usum[64];
    end else begin
      exact         = sa - sb;
      t.flags.carry = is32 ? (a[31:0] >= b[31:0]) : (a >= b);  // No borrow.
    end
    t.flags.overflow = (exact != kept);  // True value does not fit.
  end
  return t;
endfunction

`endif

/* sim/alu_lane_tb.sv */
// Self-checking testbench for the ALU lane; LFSR stimulus against a model, started by run.sh.
`timescale 1ns/1ps

module alu_lane_tb
  import alu_pkg::*;
();

  `include "alu_model.svh"

  localparam logic [16:0] SEED        = 17'd66358;
  localparam int          DRAIN_LIMIT = 8;

  typedef struct packed {
    logic     valid;
    word_t    result;
    alu_ret_t ret;
  } expect_t;

  logic        clk;
  logic        rst;
  logic        flush;
  alu_issue_t  issue;
  fwd_bus_t    fwd_bus;
  word_t       result;
  alu_ret_t    ret;
  logic        result_valid;
  logic [16:0] lfsr;
  expect_t     pipe [2];  // Slot 0 issued last step, slot 1 in execute.
  int          errors;
  int          checks;
  int          results;
  int          issued;
  int          tests;

  alu_lane alu_lane_i (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .issue        (issue),
    .fwd_bus      (fwd_bus),
    .result       (result),
    .ret          (ret),
    .result_valid (result_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Taps 17 and 14, one step per bit.
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[16] ^ lfsr[13];
      lfsr = {lfsr[15:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic alu_issue_t random_issue(input int kind, input logic fwd, input logic valid);
    alu_issue_t iss;
    int         pick;
    iss       = '0;
    iss.valid = valid;
    case (kind)
      0: begin
        pick       = int'(rand_bits(2) % 3);
        iss.uop.op = (pick == 2) ? op_cmp : alu_op_e'(4'(pick));
      end
      1:       iss.uop.op = alu_op_e'(4'(2 + rand_bits(3) % 6));  // Logic and shifts.
      default: iss.uop.op = alu_op_e'(4'(rand_bits(4) % 9));
    endcase
    iss.uop.is32 = (rand_bits(1) != 0);
    iss.a        = rand_bits(64);
    iss.b        = rand_bits(64);
    if (kind == 0 && rand_bits(3) == 0) begin
      iss.b = iss.a;  // Zero difference.
    end
    if (fwd) begin
      iss.a_sel.mode = fwd_mode_e'(2'(rand_bits(2) % 3));
      iss.a_sel.idx  = fwd_idx_t'(rand_bits(2));
      iss.b_sel.mode = fwd_mode_e'(2'(rand_bits(2) % 3));
      iss.b_sel.idx  = fwd_idx_t'(rand_bits(2));
    end
    return iss;
  endfunction

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_ret(input string name, input alu_ret_t expected, input alu_ret_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %0t %s expected %b got %b", $time, name, expected, actual);
    end
  endtask

  task automatic check_valid(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %0t %s expected %b got %b", $time, name, expected, actual);
    end
  endtask

  // One clock: check what came out, advance the model, drive the next inputs.
  task automatic cycle(input alu_issue_t iss, input logic fl);
    expect_t  exp_out;
    fwd_bus_t bus_new;
    word_t    a;
    word_t    b;
    int       i;
    @(posedge clk);
    #1;
    exp_out       = pipe[1];
    exp_out.valid = pipe[1].valid & ~flush;
    pipe[1]       = pipe[0];
    pipe[1].valid = pipe[0].valid & ~flush;  // Flush seen at this edge.
    check_valid("result_valid", exp_out.valid, result_valid);
    if (exp_out.valid) begin
      check_word("result", exp_out.result, result);
      check_ret("ret", exp_out.ret, ret);
    end
    if (result_valid === 1'b1) begin
      results++;
    end
    for (i = 0; i < NUM_FWD; i++) begin
      bus_new[i] = rand_bits(64);
    end
    a              = expect_operand(iss.a, iss.a_sel, bus_new, fwd_bus);
    b              = expect_operand(iss.b, iss.b_sel, bus_new, fwd_bus);
    pipe[0].valid  = iss.valid;
    pipe[0].result = expect_result(iss.uop.op, iss.uop.is32, a, b);
    pipe[0].ret    = expect_ret(iss.uop.op, iss.uop.is32, a, b);
    if (iss.valid) begin
      issued++;
    end
    issue   = iss;
    flush   = fl;
    fwd_bus = bus_new;
  endtask

  task automatic drain(input string name);
    int waited;
    waited = 0;
    while (pipe[0].valid || pipe[1].valid || result_valid) begin
      if (waited == DRAIN_LIMIT) begin
        errors++;
        $display("timeout: lane did not drain after test %s", name);
        break;
      end
      cycle('0, 1'b0);
      waited++;
    end
  endtask

  task automatic run_test(input string name, input int kind, input int count,
                          input logic fwd, input logic every, input logic flushes);
    int   err0;
    int   res0;
    int   iss0;
    int   i;
    logic v;
    logic fl;
    err0 = errors;
    res0 = results;
    iss0 = issued;
    for (i = 0; i < count; i++) begin
      v  = every | (rand_bits(1) != 0);
      fl = flushes & (rand_bits(3) == 0);
      cycle(random_issue(kind, fwd, v), fl);
    end
    drain(name);
    if (!flushes && (results - res0 != issued - iss0)) begin
      errors++;
      $display("%s: %0d ops issued but %0d results came out", name, issued - iss0,
               results - res0);
    end
    tests++;
    $display("test %s done, %0d results, %0d errors", name, results - res0, errors - err0);
  endtask

  task automatic reset_test();
    int i;
    int err0;
    err0 = errors;
    rst  = 1'b1;
    for (i = 0; i < 4; i++) begin
      @(posedge clk);
      #1;
      check_valid("result_valid", 1'b0, result_valid);
    end
    rst = 1'b0;
    for (i = 0; i < 3; i++) begin
      cycle('0, 1'b0);  // Nothing issued yet.
    end
    tests++;
    $display("test reset done, %0d errors", errors - err0);
  endtask

  initial begin
    lfsr    = SEED;
    errors  = 0;
    checks  = 0;
    results = 0;
    issued  = 0;
    tests   = 0;
    pipe[0] = '0;
    pipe[1] = '0;
    rst     = 1'b1;
    flush   = 1'b0;
    issue   = '0;
    fwd_bus = '0;
    reset_test();
    run_test("arith", 0, 80, 1'b0, 1'b0, 1'b0);
    run_test("logic_shift", 1, 100, 1'b0, 1'b0, 1'b0);
    run_test("forwarding", 2, 100, 1'b1, 1'b0, 1'b0);
    run_test("back_to_back", 2, 200, 1'b1, 1'b1, 1'b0);
    run_test("flush", 2, 120, 1'b1, 1'b0, 1'b1);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+sim
design/alu_pkg.sv
design/operand_forward.sv
design/op_decode.sv
design/alu_shift.sv
design/alu_exec.sv
design/alu_lane.sv
sim/alu_lane_tb.sv

/* run.sh */
#!/bin/sh
# Builds the ALU lane testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -j 0 -Wno-fatal --top-module alu_lane_tb -f compile.f -o alu_lane_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/alu_lane_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  exit 0
fi
exit 1
